/* build.f */
+incdir+source
source/conv_data_pkg.sv
source/conv_cmd_pkg.sv
source/conv_cmd_decode.sv
source/conv_operand_buffer.sv
source/conv_mac_engine.sv
source/conv_result_port.sv
source/conv_accel_top.sv
tb/conv_accel_properties.sv
tb/conv_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module conv_accel_tb -f build.f -o sim_conv

# assertion errors must not end the run early, the testbench counts them
./obj_dir/sim_conv +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

/* source/conv_accel_top.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_accel_top
   import conv_data_pkg::*;
   import conv_cmd_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         hold_i,
   input  conv_cmd_t    cmd_i,
   output conv_result_t result_o,
   output logic         stall_o
);

   conv_load_t             filter_load;
   conv_load_t             data_load;
   logic                   clear_filter;
   logic                   clear_data;
   logic                   run;
   logic                   done;
   logic                   pair_ready;
   logic [`CONV_IDX_W-1:0] rd_idx;
   filter_coef_t           coef;
   data_sample_t           sample;
   logic                   coef_filled;
   logic                   sample_filled;
   word_t                  accum;

   conv_cmd_decode u_decode (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .hold_i         (hold_i),
      .cmd_i          (cmd_i),
      .done_i         (done),
      .stall_i        (stall_o),
      .filter_load_o  (filter_load),
      .data_load_o    (data_load),
      .clear_filter_o (clear_filter),
      .clear_data_o   (clear_data),
      .run_o          (run)
   );

   // coefficient side
   conv_operand_buffer #(.elem_t(filter_coef_t)) u_filter_buf (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .hold_i      (hold_i),
      .load_i      (filter_load),
      .clear_i     (clear_filter),
      .rd_idx_i    (rd_idx),
      .rd_elem_o   (coef),
      .rd_filled_o (coef_filled)
   );

   // sample side
   conv_operand_buffer #(.elem_t(data_sample_t)) u_data_buf (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .hold_i      (hold_i),
      .load_i      (data_load),
      .clear_i     (clear_data),
      .rd_idx_i    (rd_idx),
      .rd_elem_o   (sample),
      .rd_filled_o (sample_filled)
   );

   // either clear restarts the sum
   conv_mac_engine u_engine (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .hold_i          (hold_i),
      .clear_i         (clear_filter | clear_data),
      .coef_i          (coef),
      .sample_i        (sample),
      .coef_filled_i   (coef_filled),
      .sample_filled_i (sample_filled),
      .rd_idx_o        (rd_idx),
      .pair_ready_o    (pair_ready),
      .accum_o         (accum),
      .done_o          (done)
   );

   conv_result_port u_result (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .hold_i       (hold_i),
      .run_i        (run),
      .done_i       (done),
      .pair_ready_i (pair_ready),
      .accum_i      (accum),
      .result_o     (result_o),
      .stall_o      (stall_o)
   );

endmodule

/* source/conv_cmd_decode.sv */
`timescale 1ns/1ps

module conv_cmd_decode
   import conv_data_pkg::*;
   import conv_cmd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       hold_i,
   input  conv_cmd_t  cmd_i,
   input  logic       done_i,
   input  logic       stall_i,
   output conv_load_t filter_load_o,
   output conv_load_t data_load_o,
   output logic       clear_filter_o,
   output logic       clear_data_o,
   output logic       run_o
);

   conv_load_t filter_load_q;
   conv_load_t data_load_q;
   logic       clear_filter_q;
   logic       clear_data_q;
   logic       run_q;
   logic       cmd_ok;
   logic       load_ok;

   // commands during a stall are ignored
   assign cmd_ok  = cmd_i.valid && !stall_i;
   // no more loads once the sum is finished
   assign load_ok = cmd_ok && !done_i;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         filter_load_q.en   <= 1'b0;
         filter_load_q.pair <= 1'b0;
         data_load_q.en     <= 1'b0;
         data_load_q.pair   <= 1'b0;
         clear_filter_q     <= 1'b0;
         clear_data_q       <= 1'b0;
         run_q              <= 1'b0;
      end else if (!hold_i) begin
         // operand words follow the command every cycle
         filter_load_q.lo_word <= cmd_i.rs1;
         filter_load_q.hi_word <= cmd_i.rs2;
         data_load_q.lo_word   <= cmd_i.rs1;
         data_load_q.hi_word   <= cmd_i.rs2;

         filter_load_q.en   <= load_ok && (cmd_i.op inside {OP_LOAD_FILTER, OP_LOAD_FILTER_PAIR});
         filter_load_q.pair <= cmd_i.op == OP_LOAD_FILTER_PAIR;
         data_load_q.en     <= load_ok && (cmd_i.op inside {OP_LOAD_DATA, OP_LOAD_DATA_PAIR});
         data_load_q.pair   <= cmd_i.op == OP_LOAD_DATA_PAIR;
         clear_filter_q     <= cmd_ok && (cmd_i.op == OP_CLEAR_FILTER);
         clear_data_q       <= cmd_ok && (cmd_i.op == OP_CLEAR_DATA);
         run_q              <= cmd_ok && (cmd_i.op == OP_RUN);
      end
   end

   assign filter_load_o  = filter_load_q;
   assign data_load_o    = data_load_q;
   assign clear_filter_o = clear_filter_q;
   assign clear_data_o   = clear_data_q;
   assign run_o          = run_q;

endmodule

/* source/conv_cmd_pkg.sv */
package conv_cmd_pkg;

   import conv_data_pkg::*;

   // decoded custom instruction
   typedef enum logic [2:0] {
      OP_NONE             = 3'd0,
      OP_LOAD_FILTER      = 3'd1,
      OP_LOAD_FILTER_PAIR = 3'd2,
      OP_LOAD_DATA        = 3'd3,
      OP_LOAD_DATA_PAIR   = 3'd4,
      OP_CLEAR_FILTER     = 3'd5,
      OP_CLEAR_DATA       = 3'd6,
      OP_RUN              = 3'd7
   } conv_op_e;

   // command as issued by the execute stage
   typedef struct packed {
      logic     valid;
      conv_op_e op;
      // register operands
      word_t    rs1;
      word_t    rs2;
   } conv_cmd_t;

endpackage

/* source/conv_data_pkg.sv */
`include "conv_settings.svh"

package conv_data_pkg;

   // raw operand word as it comes from the register file
   typedef logic [`CONV_WORD_W-1:0] word_t;

   // buffer elements, both signed
   typedef logic signed [`CONV_WORD_W-1:0] filter_coef_t;
   typedef logic signed [`CONV_WORD_W-1:0] data_sample_t;

   // write request into one operand buffer
   typedef struct packed {
      logic  en;
      // second word goes to index plus one
      logic  pair;
      word_t lo_word;
      word_t hi_word;
   } conv_load_t;

   // result towards the core
   typedef struct packed {
      // one cycle strobe
      logic  valid;
      // all entries were summed
      logic  complete;
      word_t value;
   } conv_result_t;

endpackage

/* source/conv_mac_engine.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_mac_engine
   import conv_data_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   hold_i,
   input  logic                   clear_i,
   input  filter_coef_t           coef_i,
   input  data_sample_t           sample_i,
   input  logic                   coef_filled_i,
   input  logic                   sample_filled_i,
   output logic [`CONV_IDX_W-1:0] rd_idx_o,
   output logic                   pair_ready_o,
   output word_t                  accum_o,
   output logic                   done_o
);

   localparam logic [`CONV_IDX_W-1:0] LAST_IDX = `CONV_IDX_W'(`CONV_DEPTH - 1);

   word_t                  product_q;
   logic                   phase_q;
   logic [`CONV_IDX_W-1:0] idx_q;
   word_t                  accum_q;
   logic                   done_q;
   logic                   pair_ready;
   logic                   mult_go;

   // both operands present at the current index
   assign pair_ready = coef_filled_i && sample_filled_i;
   assign mult_go    = !hold_i && !clear_i && !phase_q && pair_ready && !done_q;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         phase_q <= 1'b0;
         idx_q   <= '0;
         accum_q <= '0;
         done_q  <= 1'b0;
      end else if (!hold_i) begin
         if (clear_i) begin
            phase_q <= 1'b0;
            idx_q   <= '0;
            accum_q <= '0;
            done_q  <= 1'b0;
         end else if (phase_q) begin
            // second phase, accumulate and step
            accum_q <= accum_q + product_q;
            idx_q   <= idx_q + 1'b1;
            phase_q <= 1'b0;
            if (idx_q == LAST_IDX) begin
               done_q <= 1'b1;
            end
         end else if (pair_ready && !done_q) begin
            // first phase, product goes into its register
            phase_q <= 1'b1;
         end
      end
   end

   // sum wraps at the word width
   always_ff @(posedge clk_i) begin
      if (mult_go) begin
         product_q <= word_t'(coef_i * sample_i);
      end
   end

   assign rd_idx_o     = idx_q;
   assign pair_ready_o = pair_ready;
   assign accum_o      = accum_q;
   assign done_o       = done_q;

endmodule

/* source/conv_operand_buffer.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_operand_buffer
   import conv_data_pkg::*;
#(
   parameter type elem_t = word_t
) (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   hold_i,
   input  conv_load_t             load_i,
   input  logic                   clear_i,
   input  logic [`CONV_IDX_W-1:0] rd_idx_i,
   output elem_t                  rd_elem_o,
   output logic                   rd_filled_o
);

   elem_t                  entries [`CONV_DEPTH];
   logic [`CONV_IDX_W-1:0] wr_idx;
   logic [`CONV_IDX_W-1:0] wr_idx_next;
   logic [`CONV_DEPTH-1:0] fill_mask;
   logic                   wr_en;

   // a clear wins over a load in the same cycle
   assign wr_en       = load_i.en && !clear_i && !hold_i;
   // second slot of a pair, wraps past the last entry
   assign wr_idx_next = wr_idx + 1'b1;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_idx    <= '0;
         fill_mask <= '0;
      end else if (!hold_i) begin
         if (clear_i) begin
            wr_idx    <= '0;
            fill_mask <= '0;
         end else if (load_i.en) begin
            fill_mask[wr_idx] <= 1'b1;
            if (load_i.pair) begin
               fill_mask[wr_idx_next] <= 1'b1;
               wr_idx                 <= wr_idx + 2'd2;
            end else begin
               wr_idx <= wr_idx_next;
            end
         end
      end
   end

   // entry storage
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         entries[wr_idx] <= elem_t'(load_i.lo_word);
         if (load_i.pair) begin
            entries[wr_idx_next] <= elem_t'(load_i.hi_word);
         end
      end
   end

   assign rd_elem_o   = entries[rd_idx_i];
   assign rd_filled_o = fill_mask[rd_idx_i];

endmodule

/* source/conv_result_port.sv */
`timescale 1ns/1ps

module conv_result_port
   import conv_data_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         hold_i,
   input  logic         run_i,
   input  logic         done_i,
   input  logic         pair_ready_i,
   input  word_t        accum_i,
   output conv_result_t result_o,
   output logic         stall_o
);

   conv_result_t result_q;
   logic         stall_q;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         result_q.valid    <= 1'b0;
         result_q.complete <= 1'b0;
         stall_q           <= 1'b0;
      end else if (hold_i) begin
         // strobe never repeats while frozen
         result_q.valid <= 1'b0;
      end else begin
         result_q.valid <= 1'b0;
         if (stall_q) begin
            // waiting for the engine to finish
            if (done_i) begin
               stall_q           <= 1'b0;
               result_q.valid    <= 1'b1;
               result_q.complete <= 1'b1;
               result_q.value    <= accum_i;
            end
         end else if (run_i) begin
            if (done_i || !pair_ready_i) begin
               // finished sum, or partial sum when nothing is left to compute
               result_q.valid    <= 1'b1;
               result_q.complete <= done_i;
               result_q.value    <= accum_i;
            end else begin
               stall_q <= 1'b1;
            end
         end
      end
   end

   assign result_o = result_q;
   assign stall_o  = stall_q;

endmodule

/* source/conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// operand and accumulator width
`define CONV_WORD_W 32

// entries per buffer, index wide enough to address them
`define CONV_DEPTH  16
`define CONV_IDX_W  4

`endif

/* tb/conv_accel_properties.sv */
`timescale 1ns/1ps

module conv_accel_properties
   import conv_data_pkg::*;
(
   input logic         clk_i,
   input logic         rst_i,
   input logic         hold_i,
   input logic         run_i,
   input logic         done_i,
   input logic         pair_ready_i,
   input logic         stall_i,
   input conv_result_t result_i,
   input word_t        exp_value_i,
   input logic         exp_complete_i
);

   int unsigned fail_count = 0;
   logic        run_seen;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         run_seen <= 1'b0;
      end else if (run_i) begin
         run_seen <= 1'b1;
      end
   end

   a_quiet_before_run: assert property (@(posedge clk_i) disable iff (!rst_i)
      !run_seen |-> !stall_i && !result_i.valid)
      else begin
         fail_count++;
         $error("[FAIL] %0t stall or result seen before any run", $time);
      end

   a_result_value: assert property (@(posedge clk_i) disable iff (!rst_i)
      result_i.valid |-> result_i.value == exp_value_i && result_i.complete == exp_complete_i)
      else begin
         fail_count++;
         $error("[FAIL] %0t result %h complete %0b, expected %h complete %0b", $time,
                result_i.value, result_i.complete, exp_value_i, exp_complete_i);
      end

   a_single_strobe: assert property (@(posedge clk_i) disable iff (!rst_i)
      result_i.valid |=> !result_i.valid)
      else begin
         fail_count++;
         $error("[FAIL] %0t result strobe longer than one cycle", $time);
      end

   a_no_stall_with_strobe: assert property (@(posedge clk_i) disable iff (!rst_i)
      result_i.valid |-> !stall_i)
      else begin
         fail_count++;
         $error("[FAIL] %0t stall high together with the result strobe", $time);
      end

   // done or nothing left to compute answers at once
   a_immediate_result: assert property (@(posedge clk_i) disable iff (!rst_i)
      run_i && !hold_i && !stall_i && (done_i || !pair_ready_i) |=> result_i.valid && !stall_i)
      else begin
         fail_count++;
         $error("[FAIL] %0t run without pending work gave no result next cycle", $time);
      end

   a_stall_start: assert property (@(posedge clk_i) disable iff (!rst_i)
      run_i && !hold_i && !stall_i && !done_i && pair_ready_i |=> stall_i && !result_i.valid)
      else begin
         fail_count++;
         $error("[FAIL] %0t run with pending work did not stall", $time);
      end

   a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
      stall_i && !done_i |=> stall_i)
      else begin
         fail_count++;
         $error("[FAIL] %0t stall dropped before done", $time);
      end

   a_stall_release: assert property (@(posedge clk_i) disable iff (!rst_i)
      stall_i && done_i && !hold_i |=> result_i.valid && !stall_i)
      else begin
         fail_count++;
         $error("[FAIL] %0t no result in the cycle after done", $time);
      end

endmodule

/* tb/conv_accel_tb.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_accel_tb
   import conv_data_pkg::*;
   import conv_cmd_pkg::*;
();

   logic         clk;
   logic         rst;
   logic         hold;
   conv_cmd_t    cmd;
   conv_result_t result;
   logic         stall;

   // reference model of both buffers
   word_t                  f_buf [`CONV_DEPTH];
   word_t                  d_buf [`CONV_DEPTH];
   logic [`CONV_DEPTH-1:0] f_fill;
   logic [`CONV_DEPTH-1:0] d_fill;
   logic [`CONV_IDX_W-1:0] f_wr;
   logic [`CONV_IDX_W-1:0] d_wr;
   logic                   model_done;
   word_t                  exp_value;
   logic                   exp_complete;
   int                     timeouts;

   conv_accel_top dut (
      .clk_i    (clk),
      .rst_i    (rst),
      .hold_i   (hold),
      .cmd_i    (cmd),
      .result_o (result),
      .stall_o  (stall)
   );

   bind conv_accel_top conv_accel_properties u_props (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .hold_i         (hold_i),
      .run_i          (run),
      .done_i         (done),
      .pair_ready_i   (pair_ready),
      .stall_i        (stall_o),
      .result_i       (result_o),
      .exp_value_i    (conv_accel_tb.exp_value),
      .exp_complete_i (conv_accel_tb.exp_complete)
   );

   always #5 clk = ~clk;

   task automatic send(input conv_op_e op, input word_t rs1, input word_t rs2);
      conv_cmd_t c;
      c.valid = 1'b1;
      c.op    = op;
      c.rs1   = rs1;
      c.rs2   = rs2;
      @(posedge clk);
      cmd <= c;
      @(posedge clk);
      cmd <= '0;
   endtask

   task automatic model_write(input logic to_filter, input logic pair,
                              input word_t lo, input word_t hi);
      // loads after done never reach the buffers
      if (model_done) begin
         return;
      end
      if (to_filter) begin
         f_buf[f_wr]  = lo;
         f_fill[f_wr] = 1'b1;
         if (pair) begin
            f_buf[f_wr + 4'd1]  = hi;
            f_fill[f_wr + 4'd1] = 1'b1;
         end
         f_wr = f_wr + (pair ? 4'd2 : 4'd1);
      end else begin
         d_buf[d_wr]  = lo;
         d_fill[d_wr] = 1'b1;
         if (pair) begin
            d_buf[d_wr + 4'd1]  = hi;
            d_fill[d_wr + 4'd1] = 1'b1;
         end
         d_wr = d_wr + (pair ? 4'd2 : 4'd1);
      end
   endtask

   task automatic model_clear(input logic to_filter);
      if (to_filter) begin
         f_fill = '0;
         f_wr   = '0;
      end else begin
         d_fill = '0;
         d_wr   = '0;
      end
      model_done = 1'b0;
   endtask

   // random mix of single and pair loads, never past the last entry
   task automatic load_entries(input logic to_filter, input int count);
      int       left;
      logic     pair;
      word_t    lo;
      word_t    hi;
      conv_op_e op;
      left = count;
      while (left > 0) begin
         pair = (left >= 2) && ($urandom_range(1, 0) == 1);
         lo   = $urandom;
         hi   = $urandom;
         if (to_filter) begin
            op = pair ? OP_LOAD_FILTER_PAIR : OP_LOAD_FILTER;
         end else begin
            op = pair ? OP_LOAD_DATA_PAIR : OP_LOAD_DATA;
         end
         send(op, lo, hi);
         model_write(to_filter, pair, lo, hi);
         left = left - (pair ? 2 : 1);
      end
   endtask

   // walk from index 0 while both entries are present, sum wraps at 32 bits
   task automatic compute_expected();
      word_t acc;
      logic  walking;
      int    count;
      acc     = '0;
      walking = 1'b1;
      count   = 0;
      for (int i = 0; i < `CONV_DEPTH; i++) begin
         if (walking && f_fill[i] && d_fill[i]) begin
            acc = acc + f_buf[i] * d_buf[i];
            count++;
         end else begin
            walking = 1'b0;
         end
      end
      exp_value    = acc;
      exp_complete = (count == `CONV_DEPTH);
   endtask

   task automatic wait_result();
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < 100) begin
         @(negedge clk);
         seen = result.valid;
         cycles++;
      end
      if (!seen) begin
         timeouts++;
         $display("%0t: no result arrived within 100 cycles of the run", $time);
      end else if (exp_complete) begin
         model_done = 1'b1;
      end
   endtask

   task automatic run_and_check();
      compute_expected();
      send(OP_RUN, '0, '0);
      wait_result();
   endtask

   // freeze the block with a command on the bus that must be ignored
   task automatic hold_with_command(input conv_op_e op, input int cycles);
      conv_cmd_t c;
      c.valid = 1'b1;
      c.op    = op;
      c.rs1   = $urandom;
      c.rs2   = $urandom;
      @(posedge clk);
      hold <= 1'b1;
      cmd  <= c;
      repeat (cycles) @(posedge clk);
      hold <= 1'b0;
      cmd  <= '0;
   endtask

   initial begin
      void'($urandom(74));
      clk        = 1'b0;
      rst        = 1'b0;
      hold       = 1'b0;
      cmd        = '0;
      f_fill     = '0;
      d_fill     = '0;
      f_wr       = '0;
      d_wr       = '0;
      model_done = 1'b0;
      timeouts   = 0;
      compute_expected();

      repeat (10) @(posedge clk);
      rst <= 1'b1;
      repeat (20) @(posedge clk);

      // partial load, engine gets time to reach the gap
      load_entries(1'b1, 6);
      load_entries(1'b0, 6);
      repeat (40) @(posedge clk);
      run_and_check();

      // fill the rest and run while the engine still works
      load_entries(1'b1, 10);
      load_entries(1'b0, 10);
      run_and_check();

      // these loads arrive after done
      load_entries(1'b1, 4);
      load_entries(1'b0, 3);
      run_and_check();

      // new coefficients on the kept samples
      send(OP_CLEAR_FILTER, '0, '0);
      model_clear(1'b1);
      load_entries(1'b1, 16);
      run_and_check();

      // new samples, then a hold in the middle of the walk
      send(OP_CLEAR_DATA, '0, '0);
      model_clear(1'b0);
      load_entries(1'b0, 16);
      hold_with_command(OP_CLEAR_DATA, 12);
      run_and_check();

      repeat (5) @(posedge clk);
      $display("checks done: %0d assertion failures, %0d timeouts",
               dut.u_props.fail_count, timeouts);
      if (dut.u_props.fail_count == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
